// File: files.f
src/dii_pkg.sv
src/ring_router_pkg.sv
src/dii_channel.sv
src/ring_router_demux.sv
src/ring_router_mux.sv
src/ring_router_mux_rr.sv
src/dii_buffer.sv
src/ring_router.sv
verification/ring_router_assert.sv
verification/ring_router_tb.sv

// File: src/dii_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module dii_buffer #(
   parameter int WIDTH = 16,
   parameter int SIZE  = 4
) (
   input wire           clk,
   input wire           arst_n,
   dii_channel.receiver in,
   dii_channel.sender   out
);

   localparam int PTR_W = $clog2(SIZE);
   localparam int CNT_W = $clog2(SIZE + 1);

   typedef logic [PTR_W-1:0] ptr_t;
   typedef logic [CNT_W-1:0] cnt_t;

   // each entry holds last on top of the payload
   typedef logic [WIDTH:0] entry_t;

   entry_t mem [SIZE];
   ptr_t   wr_ptr;
   ptr_t   rd_ptr;
   cnt_t   count;
   logic   wr_en;
   logic   rd_en;
   entry_t head;

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // handshake
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   assign in.ready  = (count != cnt_t'(SIZE));
   assign out.valid = (count != '0);

   assign head      = mem[rd_ptr];
   assign out.last  = head[WIDTH];
   assign out.data  = head[WIDTH-1:0];

   assign wr_en = in.valid && in.ready;
   assign rd_en = out.valid && out.ready;

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // storage and pointers
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   always_ff @(posedge clk) begin
      if (wr_en) begin
         mem[wr_ptr] <= {in.last, in.data};
      end
   end

   // pointers wrap explicitly so SIZE need not be a power of two
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
      end else begin
         if (wr_en) begin
            wr_ptr <= (wr_ptr == ptr_t'(SIZE - 1)) ? '0 : wr_ptr + ptr_t'(1);
         end
         if (rd_en) begin
            rd_ptr <= (rd_ptr == ptr_t'(SIZE - 1)) ? '0 : rd_ptr + ptr_t'(1);
         end
      end
   end

   // a simultaneous write and read leaves the fill level alone
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         count <= '0;
      end else begin
         case ({wr_en, rd_en})
            2'b10:   count <= count + cnt_t'(1);
            2'b01:   count <= count - cnt_t'(1);
            default: count <= count;
         endcase
      end
   end

endmodule

`default_nettype wire

// File: src/dii_channel.sv
`timescale 1ns/1ps
`default_nettype none

// one flit channel with valid/ready handshake
interface dii_channel;

   logic                valid;
   logic                last;
   dii_pkg::flit_data_t data;
   logic                ready;

   // the side that produces flits
   modport sender (
      output valid,
      output last,
      output data,
      input  ready
   );

   // the side that consumes flits
   modport receiver (
      input  valid,
      input  last,
      input  data,
      output ready
   );

endinterface

`default_nettype wire

// File: src/dii_pkg.sv
`default_nettype none

package dii_pkg;

   // payload carried by a single flit
   typedef logic [15:0] flit_data_t;

   // node address, found in the low bits of the first flit of a packet
   typedef logic [9:0] node_id_t;

   // width of the address field inside the first flit
   localparam int node_id_w = $bits(node_id_t);

   // flattened channel word as seen at the top-level ports
   // bit 17 is valid and bit 16 is last, the payload fills the rest
   typedef logic [17:0] flit_bus_t;

   // bit positions inside flit_bus_t
   localparam int bus_valid_bit = 17;
   localparam int bus_last_bit  = 16;

endpackage

`default_nettype wire

// File: src/ring_router.sv
`timescale 1ns/1ps
`default_nettype none

module ring_router #(
   parameter int BUFFER_SIZE = 4
) (
   input  wire                     clk,
   input  wire                     arst_n,

   input  wire dii_pkg::node_id_t  id,

   input  wire dii_pkg::flit_bus_t ring_in0_down,
   output wire                     ring_in0_up,

   input  wire dii_pkg::flit_bus_t ring_in1_down,
   output wire                     ring_in1_up,

   output wire dii_pkg::flit_bus_t ring_out0_down,
   input  wire                     ring_out0_up,

   output wire dii_pkg::flit_bus_t ring_out1_down,
   input  wire                     ring_out1_up,

   input  wire dii_pkg::flit_bus_t local_in_down,
   output wire                     local_in_up,

   output wire dii_pkg::flit_bus_t local_out_down,
   input  wire                     local_out_up
);

   // channels at the boundary
   dii_channel ring_in0 ();
   dii_channel ring_in1 ();
   dii_channel local_in ();
   dii_channel ring_out0 ();
   dii_channel ring_out1 ();
   dii_channel local_out ();

   // channels between the blocks
   dii_channel ring0local ();
   dii_channel ring0fwd ();
   dii_channel ring1local ();
   dii_channel ring1fwd ();
   dii_channel ring0muxed ();

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // bus packing
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   assign {ring_in0.valid, ring_in0.last, ring_in0.data} = ring_in0_down;
   assign ring_in0_up = ring_in0.ready;

   assign {ring_in1.valid, ring_in1.last, ring_in1.data} = ring_in1_down;
   assign ring_in1_up = ring_in1.ready;

   assign {local_in.valid, local_in.last, local_in.data} = local_in_down;
   assign local_in_up = local_in.ready;

   assign ring_out0_down  = {ring_out0.valid, ring_out0.last, ring_out0.data};
   assign ring_out0.ready = ring_out0_up;

   assign ring_out1_down  = {ring_out1.valid, ring_out1.last, ring_out1.data};
   assign ring_out1.ready = ring_out1_up;

   assign local_out_down  = {local_out.valid, local_out.last, local_out.data};
   assign local_out.ready = local_out_up;

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // routing blocks
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   ring_router_demux u_demux0 (
      .clk       (clk),
      .arst_n    (arst_n),
      .id        (id),
      .in        (ring_in0),
      .out_local (ring0local),
      .out_ring  (ring0fwd)
   );

   ring_router_demux u_demux1 (
      .clk       (clk),
      .arst_n    (arst_n),
      .id        (id),
      .in        (ring_in1),
      .out_local (ring1local),
      .out_ring  (ring1fwd)
   );

   ring_router_mux_rr u_mux_local (
      .clk    (clk),
      .arst_n (arst_n),
      .in0    (ring0local),
      .in1    (ring1local),
      .out    (local_out)
   );

   // local injection always joins ring 0
   ring_router_mux u_mux_ring0 (
      .clk      (clk),
      .arst_n   (arst_n),
      .in_ring  (ring0fwd),
      .in_local (local_in),
      .out      (ring0muxed)
   );

   dii_buffer #(
      .WIDTH ($bits(dii_pkg::flit_data_t)),
      .SIZE  (BUFFER_SIZE)
   ) u_buffer0 (
      .clk    (clk),
      .arst_n (arst_n),
      .in     (ring0muxed),
      .out    (ring_out0)
   );

   dii_buffer #(
      .WIDTH ($bits(dii_pkg::flit_data_t)),
      .SIZE  (BUFFER_SIZE)
   ) u_buffer1 (
      .clk    (clk),
      .arst_n (arst_n),
      .in     (ring1fwd),
      .out    (ring_out1)
   );

endmodule

`default_nettype wire

// File: src/ring_router_demux.sv
`timescale 1ns/1ps
`default_nettype none

module ring_router_demux (
   input wire                    clk,
   input wire                    arst_n,
   input wire dii_pkg::node_id_t id,
   dii_channel.receiver          in,
   dii_channel.sender            out_local,
   dii_channel.sender            out_ring
);

   ring_router_pkg::route_state_t state_q;
   ring_router_pkg::route_state_t state_d;
   logic                          dest_match;
   logic                          sel_local;
   logic                          xfer;

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // target selection
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   // only meaningful on the first flit, i.e. while idle
   assign dest_match = (in.data[dii_pkg::node_id_w-1:0] == id);

   assign sel_local = (state_q == ring_router_pkg::route_to_local) ||
                      ((state_q == ring_router_pkg::route_idle) && dest_match);

   // payload fans out to both sides, valid only to the selected one
   assign out_local.valid = in.valid && sel_local;
   assign out_local.last  = in.last;
   assign out_local.data  = in.data;

   assign out_ring.valid  = in.valid && !sel_local;
   assign out_ring.last   = in.last;
   assign out_ring.data   = in.data;

   assign in.ready = sel_local ? out_local.ready : out_ring.ready;

   assign xfer = in.valid && in.ready;

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // packet state
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   always_comb begin
      state_d = state_q;
      if (xfer) begin
         // a single-flit packet never leaves idle
         if (in.last) begin
            state_d = ring_router_pkg::route_idle;
         end else if (sel_local) begin
            state_d = ring_router_pkg::route_to_local;
         end else begin
            state_d = ring_router_pkg::route_to_ring;
         end
      end
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         state_q <= ring_router_pkg::route_idle;
      end else begin
         state_q <= state_d;
      end
   end

endmodule

`default_nettype wire

// File: src/ring_router_mux.sv
`timescale 1ns/1ps
`default_nettype none

module ring_router_mux (
   input wire           clk,
   input wire           arst_n,
   dii_channel.receiver in_ring,
   dii_channel.receiver in_local,
   dii_channel.sender   out
);

   ring_router_pkg::arb_state_t state_q;
   ring_router_pkg::arb_state_t state_d;
   logic                        sel_ring;
   logic                        sel_local;
   logic                        xfer;

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // grant, ring traffic has priority
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   // with nothing offered the ring side holds the grant, so ring 0 shows ready while idle
   assign sel_ring  = (state_q == ring_router_pkg::arb_grant_a) ||
                      ((state_q == ring_router_pkg::arb_idle) &&
                       (in_ring.valid || !in_local.valid));

   // local injection only gets in between ring packets
   assign sel_local = (state_q == ring_router_pkg::arb_grant_b) ||
                      ((state_q == ring_router_pkg::arb_idle) && !in_ring.valid &&
                       in_local.valid);

   assign out.valid = (sel_ring && in_ring.valid) || (sel_local && in_local.valid);
   assign out.last  = sel_ring ? in_ring.last : in_local.last;
   assign out.data  = sel_ring ? in_ring.data : in_local.data;

   assign in_ring.ready  = sel_ring && out.ready;
   assign in_local.ready = sel_local && out.ready;

   assign xfer = out.valid && out.ready;

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // grant state
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   always_comb begin
      state_d = state_q;
      if (xfer && out.last) begin
         state_d = ring_router_pkg::arb_idle;
      end else if (out.valid) begin
         // an offered flit keeps its grant until it transfers
         state_d = sel_ring ? ring_router_pkg::arb_grant_a : ring_router_pkg::arb_grant_b;
      end
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         state_q <= ring_router_pkg::arb_idle;
      end else begin
         state_q <= state_d;
      end
   end

endmodule

`default_nettype wire

// File: src/ring_router_mux_rr.sv
`timescale 1ns/1ps
`default_nettype none

module ring_router_mux_rr (
   input wire           clk,
   input wire           arst_n,
   dii_channel.receiver in0,
   dii_channel.receiver in1,
   dii_channel.sender   out
);

   ring_router_pkg::arb_state_t state_q;
   ring_router_pkg::arb_state_t state_d;
   logic                        prio_q;
   logic                        prio_d;
   logic                        idle;
   logic                        sel0;
   logic                        sel1;
   logic                        xfer;

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // grant selection
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   // prio_q low prefers in0, high prefers in1
   assign idle = (state_q == ring_router_pkg::arb_idle);

   assign sel0 = (state_q == ring_router_pkg::arb_grant_a) ||
                 (idle && in0.valid && (!in1.valid || !prio_q));

   assign sel1 = (state_q == ring_router_pkg::arb_grant_b) ||
                 (idle && in1.valid && (!in0.valid || prio_q));

   assign out.valid = (sel0 && in0.valid) || (sel1 && in1.valid);
   assign out.last  = sel0 ? in0.last : in1.last;
   assign out.data  = sel0 ? in0.data : in1.data;

   assign in0.ready = sel0 && out.ready;
   assign in1.ready = sel1 && out.ready;

   assign xfer = out.valid && out.ready;

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // grant and priority state
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   always_comb begin
      state_d = state_q;
      prio_d  = prio_q;
      if (xfer && out.last) begin
         state_d = ring_router_pkg::arb_idle;
         // the input that just finished goes to the back
         prio_d  = sel0;
      end else if (out.valid) begin
         // a stalled flit keeps its grant so the output holds steady
         state_d = sel0 ? ring_router_pkg::arb_grant_a : ring_router_pkg::arb_grant_b;
      end
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         state_q <= ring_router_pkg::arb_idle;
         prio_q  <= 1'b0;
      end else begin
         state_q <= state_d;
         prio_q  <= prio_d;
      end
   end

endmodule

`default_nettype wire

// File: src/ring_router_pkg.sv
`default_nettype none

package ring_router_pkg;

   // packet state of a demux
   // the target is chosen on the first flit and held until last transfers
   typedef enum logic [1:0] {
      route_idle,
      route_to_local,
      route_to_ring
   } route_state_t;

   // grant state of a merge
   // grant_a and grant_b name the first and second input of each mux
   typedef enum logic [1:0] {
      arb_idle,
      arb_grant_a,
      arb_grant_b
   } arb_state_t;

endpackage

`default_nettype wire

// File: verification/ring_router_assert.sv
`timescale 1ns/1ps
`default_nettype none

module ring_router_assert (
   input wire                     clk,
   input wire                     arst_n,
   input wire dii_pkg::flit_bus_t ring_out0_down,
   input wire                     ring_out0_up,
   input wire dii_pkg::flit_bus_t ring_out1_down,
   input wire                     ring_out1_up,
   input wire dii_pkg::flit_bus_t local_out_down,
   input wire                     local_out_up
);

   // a stalled flit keeps valid, last and data until it transfers
   property held_while_stalled(dii_pkg::flit_bus_t bus, logic rdy);
      @(posedge clk) disable iff (!arst_n)
         (bus[dii_pkg::bus_valid_bit] && !rdy) |=> $stable(bus);
   endproperty

   ring_out0_hold: assert property (held_while_stalled(ring_out0_down, ring_out0_up))
      else $error("ring_out0_down changed while stalled");
   ring_out1_hold: assert property (held_while_stalled(ring_out1_down, ring_out1_up))
      else $error("ring_out1_down changed while stalled");
   local_out_hold: assert property (held_while_stalled(local_out_down, local_out_up))
      else $error("local_out_down changed while stalled");

   reset_idle: assert property (@(posedge clk) !arst_n |->
      !(ring_out0_down[dii_pkg::bus_valid_bit] || ring_out1_down[dii_pkg::bus_valid_bit] ||
        local_out_down[dii_pkg::bus_valid_bit]))
      else $error("an output valid was high during reset");

endmodule

bind ring_router ring_router_assert u_assert (.*);

`default_nettype wire

// File: verification/ring_router_tb.sv
`timescale 1ns/1ps
`default_nettype none

module ring_router_tb;

   localparam logic [31:0] seed = 32'h4a93_d939;
   localparam int wait_limit  = 400;
   localparam int drain_limit = 500;
   localparam int num_rows    = 14;

   // src is 0 for ring 0, 1 for ring 1 and 2 for local injection
   typedef struct packed {
      logic [1:0] src;
      logic [9:0] dest;
      logic [2:0] len;
      logic       bp;
   } row_t;

   localparam row_t rows [num_rows] = '{
      '{2'd0, 10'h05A, 3'd3, 1'b0},
      '{2'd1, 10'h05A, 3'd4, 1'b0},
      '{2'd0, 10'h123, 3'd2, 1'b0},
      '{2'd1, 10'h0A5, 3'd5, 1'b0},
      '{2'd2, 10'h300, 3'd3, 1'b0},
      '{2'd2, 10'h05A, 3'd2, 1'b0},
      '{2'd0, 10'h05A, 3'd6, 1'b1},
      '{2'd1, 10'h05A, 3'd2, 1'b1},
      '{2'd0, 10'h1FF, 3'd4, 1'b1},
      '{2'd2, 10'h045, 3'd6, 1'b1},
      '{2'd1, 10'h2C0, 3'd3, 1'b1},
      '{2'd0, 10'h05A, 3'd2, 1'b1},
      '{2'd1, 10'h05A, 3'd5, 1'b1},
      '{2'd2, 10'h15A, 3'd4, 1'b1}
   };

   logic               clk;
   logic               arst_n;
   dii_pkg::node_id_t  id;
   dii_pkg::flit_bus_t in_bus [3];
   wire  [2:0]         in_up;
   wire  dii_pkg::flit_bus_t out_bus [3];
   logic [2:0]         out_ready;

   // expected {last, data} per output and source, indexed output * 3 + source
   logic [16:0] exp_q [9][$];
   logic [2:0]  first_flit;
   int          bp_count;
   int          last_local_src;
   int          value_errors;
   int          other_errors;
   string       out_names [3] = '{"ring_out0_down", "ring_out1_down", "local_out_down"};

   ring_router #(
      .BUFFER_SIZE (4)
   ) dut (
      .clk            (clk),
      .arst_n         (arst_n),
      .id             (id),
      .ring_in0_down  (in_bus[0]),
      .ring_in0_up    (in_up[0]),
      .ring_in1_down  (in_bus[1]),
      .ring_in1_up    (in_up[1]),
      .ring_out0_down (out_bus[0]),
      .ring_out0_up   (out_ready[0]),
      .ring_out1_down (out_bus[1]),
      .ring_out1_up   (out_ready[1]),
      .local_in_down  (in_bus[2]),
      .local_in_up    (in_up[2]),
      .local_out_down (out_bus[2]),
      .local_out_up   (out_ready[2])
   );

   always #10 clk = ~clk;

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // expected traffic
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   function automatic logic [15:0] flit_word(input int r, input int i);
      if (i == 0) begin
         return 16'(rows[r].dest);
      end
      if (i == 1) begin
         return {4'(rows[r].src), 12'(r)};
      end
      return 16'(r + i);
   endfunction

   // ring packets for this node leave locally, everything else stays on its ring
   function automatic int target_output(input int r);
      case (rows[r].src)
         2'd0:    return (rows[r].dest == id) ? 2 : 0;
         2'd1:    return (rows[r].dest == id) ? 2 : 1;
         default: return 0;
      endcase
   endfunction

   function automatic int pending_flits();
      int n;
      n = 0;
      for (int q = 0; q < 9; q++) begin
         n += exp_q[q].size();
      end
      return n;
   endfunction

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
      if (got !== exp) begin
         value_errors++;
         $display("Fail %s: got 0x%0h, expected 0x%0h", name, got, exp);
      end
   endtask

   task automatic check_flit(input int o, input int src, input logic [16:0] flit);
      if (src > 2) begin
         other_errors++;
         $display("%s delivered a packet with an unknown source code %0d", out_names[o], src);
      end else if (exp_q[o * 3 + src].size() == 0) begin
         other_errors++;
         $display("%s delivered a flit from source %0d that was not expected there",
                  out_names[o], src);
      end else begin
         check_value(out_names[o], flit, exp_q[o * 3 + src].pop_front());
      end
   endtask

   // two first flits for this node at once, the ring not served last must win
   task automatic check_alternation();
      if (in_bus[0][17] && in_bus[1][17] && first_flit[0] && first_flit[1] &&
          in_bus[0][9:0] == id && in_bus[1][9:0] == id) begin
         check_value("ring_in_up", {in_up[1], in_up[0]}, (last_local_src == 0) ? 2'b10 : 2'b01);
      end
   endtask

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // drivers and monitors
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   task automatic drive_source(input int src);
      int t;
      int gap;
      for (int r = 0; r < num_rows; r++) begin
         if (rows[r].src == src) begin
            for (int i = 0; i < rows[r].len; i++) begin
               exp_q[target_output(r) * 3 + src].push_back({i == rows[r].len - 1,
                                                            flit_word(r, i)});
            end
            if (rows[r].bp) begin
               bp_count++;
            end
            for (int i = 0; i < rows[r].len; i++) begin
               in_bus[src]     = {1'b1, i == rows[r].len - 1, flit_word(r, i)};
               first_flit[src] = (i == 0);
               t = 0;
               @(negedge clk);
               while (!in_up[src]) begin
                  t++;
                  if (t > wait_limit) begin
                     other_errors++;
                     $display("source %0d was never accepted on row %0d flit %0d", src, r, i);
                     in_bus[src]     = '0;
                     first_flit[src] = 1'b0;
                     return;
                  end
                  @(negedge clk);
               end
               @(posedge clk);
               #1;
            end
            in_bus[src]     = '0;
            first_flit[src] = 1'b0;
            if (rows[r].bp) begin
               bp_count--;
            end
            gap = $urandom_range(2, 0);
            repeat (gap) begin
               @(posedge clk);
               #1;
            end
         end
      end
   endtask

   // all three outputs stall at random while a flagged row is in flight
   task automatic drive_ready();
      forever begin
         @(posedge clk);
         #1;
         for (int o = 0; o < 3; o++) begin
            out_ready[o] = (bp_count > 0) ? ($urandom_range(3, 0) != 0) : 1'b1;
         end
      end
   endtask

   task automatic watch_output(input int o);
      logic [16:0] flit;
      logic [16:0] head;
      logic        stalled;
      int          pos;
      int          src;
      pos     = 0;
      src     = 0;
      head    = '0;
      stalled = 1'b0;
      forever begin
         @(negedge clk);
         if (arst_n && out_bus[o][17] && out_ready[o]) begin
            flit = out_bus[o][16:0];
            if (pos == 0) begin
               head = flit;
               // a first flit offered earlier already holds the grant
               if (o == 2 && !stalled) begin
                  check_alternation();
               end
            end else if (pos == 1) begin
               src = flit[15:12];
               check_flit(o, src, head);
               check_flit(o, src, flit);
            end else begin
               check_flit(o, src, flit);
            end
            if (flit[16]) begin
               pos = 0;
               if (o == 2) begin
                  last_local_src = src;
               end
            end else begin
               pos++;
            end
         end
         stalled = arst_n && out_bus[o][17] && !out_ready[o];
      end
   endtask

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // main sequence
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   initial begin
      int t;
      int pending;
      void'($urandom(seed));
      clk            = 1'b0;
      arst_n         = 1'b0;
      id             = 10'h05A;
      out_ready      = '1;
      first_flit     = '0;
      bp_count       = 0;
      last_local_src = 1;
      value_errors   = 0;
      other_errors   = 0;
      for (int s = 0; s < 3; s++) begin
         in_bus[s] = '0;
      end
      fork
         drive_ready();
         watch_output(0);
         watch_output(1);
         watch_output(2);
      join_none

      repeat (9) @(posedge clk);
      @(negedge clk);
      check_value("output valids in reset", {out_bus[2][17], out_bus[1][17], out_bus[0][17]}, 0);
      @(posedge clk);
      #1;
      arst_n = 1'b1;
      @(negedge clk);
      check_value("output valids after reset", {out_bus[2][17], out_bus[1][17], out_bus[0][17]},
                  0);
      check_value("ring_in_up", {in_up[1], in_up[0]}, 2'b11);
      @(posedge clk);
      #1;

      fork
         drive_source(0);
         drive_source(1);
         drive_source(2);
      join

      t       = 0;
      pending = pending_flits();
      while (pending != 0 && t < drain_limit) begin
         @(negedge clk);
         t++;
         pending = pending_flits();
      end
      if (pending != 0) begin
         other_errors++;
         $display("%0d expected flits never arrived at the outputs", pending);
      end

      $display("value mismatches: %0d, other errors: %0d", value_errors, other_errors);
      if (value_errors == 0 && other_errors == 0) begin
         $display("Testbench passed");
      end else begin
         $display("Testbench failed");
      end
      $finish;
   end

endmodule

`default_nettype wire
